//--- swu_chk.sv
`timescale 1ns/1ns

module swu_chk
   import swu_stream_pkg::*;
(
   input logic  clk,
   input logic  resetn,
   input logic  s_ready_o,
   input word_t m_data_o,
   input logic  m_valid_o,
   input logic  m_ready_i
);

   int fail_count = 0;

   ////////////////////
   // stream properties
   ////////////////////

   // a stalled word stays put until taken
   property hold_while_stalled;
      @(posedge clk) disable iff (!resetn)
         (m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_data_o));
   endproperty

   property known_handshake;
      @(posedge clk) disable iff (!resetn)
         !$isunknown({s_ready_o, m_valid_o});
   endproperty

   property idle_after_reset;
      @(posedge clk) !resetn |=> !m_valid_o;
   endproperty

   hold_a: assert property (hold_while_stalled)
      else begin
         fail_count++;
         $error("output word changed or dropped while m_ready_i was low");
      end

   known_a: assert property (known_handshake)
      else begin
         fail_count++;
         $error("unknown value on s_ready_o or m_valid_o");
      end

   reset_a: assert property (idle_after_reset)
      else begin
         fail_count++;
         $error("m_valid_o high in the cycle after reset");
      end

endmodule

//--- swu_geom_pkg.sv
`include "swu_macros.svh"

package swu_geom_pkg;

   // field widths, never below one bit
   localparam int IDX_W  = $clog2(`SWU_FRAME_WORDS + 1);
   localparam int ADDR_W = $clog2(`SWU_BUF_DEPTH);
   localparam int KPOS_W = (`SWU_K > 1) ? $clog2(`SWU_K) : 1;
   localparam int CHW_W  = (`SWU_CH_WORDS > 1) ? $clog2(`SWU_CH_WORDS) : 1;
   localparam int OCOL_W = (`SWU_OFM_W > 1) ? $clog2(`SWU_OFM_W) : 1;
   localparam int OROW_W = (`SWU_OFM_H > 1) ? $clog2(`SWU_OFM_H) : 1;

   // linear word index within one frame
   typedef logic [IDX_W-1:0] elem_idx_t;

   // line buffer address
   typedef logic [ADDR_W-1:0] buf_addr_t;

   // kernel row or column
   typedef logic [KPOS_W-1:0] kpos_t;

   // channel group within a pixel
   typedef logic [CHW_W-1:0] chw_t;

   // output pixel position
   typedef logic [OCOL_W-1:0] ofm_col_t;
   typedef logic [OROW_W-1:0] ofm_row_t;

endpackage

//--- swu_line_buffer.sv
`timescale 1ns/1ns
`include "swu_macros.svh"

module swu_line_buffer
   import swu_geom_pkg::*, swu_stream_pkg::*;
(
   input  logic      clk,
   input  logic      resetn,
   input  word_t     s_data_i,
   input  logic      s_valid_i,
   output logic      s_ready_o,
   input  logic      rd_en_i,
   input  buf_addr_t rd_addr_i,
   input  elem_idx_t release_base_i,
   input  logic      frame_done_i,
   output word_t     rd_data_o,
   output elem_idx_t wr_count_o
);

   localparam int DEPTH = `SWU_BUF_DEPTH;

   word_t     mem [DEPTH];
   word_t     rd_data_q;
   buf_addr_t wr_ptr_q;
   elem_idx_t wr_count_q;
   logic      wr_en;

   // one bit wider so base plus depth cannot wrap
   logic [IDX_W:0] fill_limit;
   logic [IDX_W:0] wr_count_ext;

   ////////////////////
   // input acceptance
   ////////////////////

   assign fill_limit   = {1'b0, release_base_i} + (IDX_W+1)'(DEPTH);
   assign wr_count_ext = {1'b0, wr_count_q};

   // room left behind the oldest word still needed, and frame not complete
   assign s_ready_o = (wr_count_ext < fill_limit) &&
                      (wr_count_q < elem_idx_t'(`SWU_FRAME_WORDS));

   assign wr_en = s_valid_i && s_ready_o;

   ////////////////////
   // write side
   ////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         wr_ptr_q   <= '0;
         wr_count_q <= '0;
      end else if (wr_en) begin
         // circular pointer
         if (wr_ptr_q == buf_addr_t'(DEPTH - 1)) begin
            wr_ptr_q <= '0;
         end else begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         wr_count_q <= wr_count_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= s_data_i;
      end
   end

   ////////////////////
   // read side
   ////////////////////

   // registered read, data valid the cycle after rd_en
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_q <= mem[rd_addr_i];
      end
   end

   assign rd_data_o  = rd_data_q;
   assign wr_count_o = wr_count_q;

endmodule

//--- swu_macros.svh
`ifndef SWU_MACROS_SVH
`define SWU_MACROS_SVH

// channel word format
`define SWU_PREC        4
`define SWU_SIMD        2
`define SWU_CHANNELS    8
`define SWU_CH_WORDS    (`SWU_CHANNELS / `SWU_SIMD)

// input feature map and kernel
`define SWU_IFM_W       6
`define SWU_IFM_H       6
`define SWU_K           3
`define SWU_STRIDE      1

// derived geometry
`define SWU_OFM_W       (((`SWU_IFM_W - `SWU_K) / `SWU_STRIDE) + 1)
`define SWU_OFM_H       (((`SWU_IFM_H - `SWU_K) / `SWU_STRIDE) + 1)
`define SWU_BUF_DEPTH   (`SWU_K * `SWU_IFM_W * `SWU_CH_WORDS)
`define SWU_FRAME_WORDS (`SWU_IFM_W * `SWU_IFM_H * `SWU_CH_WORDS)
`define SWU_OUT_WORDS   (`SWU_OFM_W * `SWU_OFM_H * `SWU_K * `SWU_K * `SWU_CH_WORDS)

`endif

//--- swu_out_pipe.sv
`timescale 1ns/1ns

module swu_out_pipe
   import swu_stream_pkg::*;
(
   input  logic  clk,
   input  logic  resetn,
   input  logic  rd_en_i,
   input  logic  rd_last_i,
   input  word_t rd_data_i,
   output word_t m_data_o,
   output logic  m_valid_o,
   input  logic  m_ready_i,
   output logic  pipe_free_o,
   output logic  frame_done_o
);

   localparam int CNT_W  = $clog2(SWU_PIPE_ENTRIES + 1);
   localparam int SLOT_W = $clog2(SWU_PIPE_ENTRIES);

   word_t              data_q [SWU_PIPE_ENTRIES];
   logic               last_q [SWU_PIPE_ENTRIES];
   logic [CNT_W-1:0]   count_q;
   logic               inflight_q;
   logic               inflight_last_q;

   logic               push;
   logic               pop;
   logic [SLOT_W-1:0]  wr_slot;
   logic [CNT_W:0]     occupancy;

   assign push = inflight_q;
   assign pop  = m_valid_o && m_ready_i;

   // slot after this cycle's pop
   assign wr_slot = SLOT_W'(count_q - CNT_W'(pop));

   // a word leaving this cycle frees its slot
   assign occupancy   = (CNT_W+1)'(count_q) + (CNT_W+1)'(inflight_q) - (CNT_W+1)'(pop);
   assign pipe_free_o = occupancy < (CNT_W+1)'(SWU_PIPE_ENTRIES);

   ////////////////////
   // memory latency
   ////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         inflight_q <= 1'b0;
      end else begin
         inflight_q <= rd_en_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         inflight_last_q <= rd_last_i;
      end
   end

   ////////////////////
   // queue
   ////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         count_q <= '0;
      end else begin
         count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
      end
   end

   // shift toward the head, then land the returning word
   always_ff @(posedge clk) begin
      if (pop) begin
         for (int i = 0; i < SWU_PIPE_ENTRIES - 1; i++) begin
            data_q[i] <= data_q[i+1];
            last_q[i] <= last_q[i+1];
         end
      end
      if (push) begin
         data_q[wr_slot] <= rd_data_i;
         last_q[wr_slot] <= inflight_last_q;
      end
   end

   assign m_valid_o    = (count_q != '0);
   assign m_data_o     = data_q[0];
   assign frame_done_o = pop && last_q[0];

endmodule

//--- swu_stream_pkg.sv
`include "swu_macros.svh"

package swu_stream_pkg;

   // one stream word, SIMD channels packed
   typedef logic [`SWU_SIMD*`SWU_PREC-1:0] word_t;

   // output stage depth
   localparam int SWU_PIPE_ENTRIES = 2;

endpackage

//--- swu_tb.sv
`timescale 1ns/1ns
`include "swu_macros.svh"

module swu_tb
   import swu_stream_pkg::*;
();

   localparam int DEPTH   = `SWU_BUF_DEPTH;
   localparam int CH      = `SWU_CH_WORDS;
   localparam int FRAME   = `SWU_FRAME_WORDS;
   localparam int TIMEOUT = 2000;

   logic  clk;
   logic  resetn;
   word_t s_data_i;
   logic  s_valid_i;
   logic  s_ready_o;
   word_t m_data_o;
   logic  m_valid_o;
   logic  m_ready_i;

   int    mismatch_count;
   int    other_count;
   int    seed;
   word_t exp_q [$];

   swu_top swu_top_i (
      .clk       (clk),
      .resetn    (resetn),
      .s_data_i  (s_data_i),
      .s_valid_i (s_valid_i),
      .s_ready_o (s_ready_o),
      .m_data_o  (m_data_o),
      .m_valid_o (m_valid_o),
      .m_ready_i (m_ready_i)
   );

   bind swu_top swu_chk swu_chk_i (
      .clk       (clk),
      .resetn    (resetn),
      .s_ready_o (s_ready_o),
      .m_data_o  (m_data_o),
      .m_valid_o (m_valid_o),
      .m_ready_i (m_ready_i)
   );

   always #50 clk = ~clk;

   ////////////////////
   // reference model
   ////////////////////

   // depends on the whole word index and the frame number
   function automatic word_t input_word(input int f, input int idx);
      return word_t'(idx * 37 + (idx >> 4) * 11 + f * 91 + 5);
   endfunction

   // output rows, output columns, kernel rows, kernel columns, channel groups
   task automatic build_expected(input int f);
      int idx;
      exp_q.delete();
      for (int orow = 0; orow < `SWU_OFM_H; orow++) begin
         for (int ocol = 0; ocol < `SWU_OFM_W; ocol++) begin
            for (int kr = 0; kr < `SWU_K; kr++) begin
               for (int kc = 0; kc < `SWU_K; kc++) begin
                  for (int cg = 0; cg < CH; cg++) begin
                     idx = ((orow * `SWU_STRIDE + kr) * `SWU_IFM_W
                            + ocol * `SWU_STRIDE + kc) * CH + cg;
                     exp_q.push_back(input_word(f, idx));
                  end
               end
            end
         end
      end
   endtask

   ////////////////////
   // stream helpers
   ////////////////////

   task automatic apply_reset();
      @(posedge clk);
      resetn    <= 1'b0;
      s_valid_i <= 1'b0;
      m_ready_i <= 1'b0;
      repeat (16) @(posedge clk);
      resetn <= 1'b1;
   endtask

   // feeds words first .. FRAME-1 of frame f
   task automatic drive_words(input int f, input int first, input bit gaps,
                              input string name);
      int idx;
      int idle;
      idx  = first;
      idle = 0;
      while (idx < FRAME && idle < TIMEOUT) begin
         @(posedge clk);
         s_valid_i <= gaps ? (($urandom % 3) != 0) : 1'b1;
         s_data_i  <= input_word(f, idx);
         @(negedge clk);
         if (s_valid_i && s_ready_o) begin
            idx++;
            idle = 0;
         end else begin
            idle++;
         end
      end
      @(posedge clk);
      s_valid_i <= 1'b0;
      if (idx < FRAME) begin
         other_count++;
         $display("%s: input timed out, only %0d of %0d words accepted", name, idx, FRAME);
      end
   endtask

   task automatic collect_outputs(input bit random_ready, input string name);
      int    count;
      int    idle;
      word_t expected;
      count = 0;
      idle  = 0;
      while (exp_q.size() > 0 && idle < TIMEOUT) begin
         @(posedge clk);
         m_ready_i <= random_ready ? (($urandom % 2) == 1) : 1'b1;
         @(negedge clk);
         if (m_valid_o && m_ready_i) begin
            expected = exp_q.pop_front();
            assert (m_data_o == expected)
               else begin
                  mismatch_count++;
                  $display("Mismatch in %s word %0d: expected %h, actual %h",
                           name, count, expected, m_data_o);
               end
            count++;
            idle = 0;
         end else begin
            idle++;
         end
      end
      if (exp_q.size() > 0) begin
         other_count++;
         $display("%s: output timed out after %0d words", name, count);
      end
   endtask

   // nothing may follow the last window word
   task automatic check_quiet(input string name);
      @(posedge clk);
      m_ready_i <= 1'b1;
      repeat (20) begin
         @(negedge clk);
         assert (!m_valid_o)
            else begin
               mismatch_count++;
               $display("Mismatch in %s extra output: expected m_valid_o 0, actual %b",
                        name, m_valid_o);
            end
      end
   endtask

   task automatic run_frame(input int f, input bit gaps, input bit random_ready,
                            input string name);
      build_expected(f);
      fork
         drive_words(f, 0, gaps, name);
         collect_outputs(random_ready, name);
      join
      check_quiet(name);
   endtask

   ////////////////////
   // tests
   ////////////////////

   task automatic test_after_reset();
      apply_reset();
      @(negedge clk);
      assert (m_valid_o == 1'b0)
         else begin
            mismatch_count++;
            $display("Mismatch in test_after_reset m_valid_o: expected 0, actual %b", m_valid_o);
         end
      assert (s_ready_o == 1'b1)
         else begin
            mismatch_count++;
            $display("Mismatch in test_after_reset s_ready_o: expected 1, actual %b", s_ready_o);
         end
   endtask

   task automatic test_single_frame();
      apply_reset();
      run_frame(0, 1'b0, 1'b0, "test_single_frame");
   endtask

   task automatic test_backpressure();
      apply_reset();
      run_frame(1, 1'b0, 1'b1, "test_backpressure");
   endtask

   task automatic test_input_gaps();
      apply_reset();
      run_frame(2, 1'b1, 1'b0, "test_input_gaps");
   endtask

   task automatic test_buffer_stall();
      int idx;
      int low_run;
      int cycles;
      apply_reset();
      build_expected(3);
      idx     = 0;
      low_run = 0;
      cycles  = 0;
      // fill until input has stayed blocked for a while
      while (low_run < 50 && cycles < TIMEOUT) begin
         @(posedge clk);
         m_ready_i <= 1'b0;
         s_valid_i <= 1'b1;
         s_data_i  <= input_word(3, idx);
         @(negedge clk);
         cycles++;
         if (s_valid_i && s_ready_o) begin
            idx++;
            low_run = 0;
         end else begin
            low_run++;
         end
      end
      if (low_run < 50) begin
         other_count++;
         $display("test_buffer_stall: input never stalled with the output blocked");
      end
      assert (idx == DEPTH)
         else begin
            mismatch_count++;
            $display("Mismatch in test_buffer_stall accepted words: expected %0d, actual %0d",
                     DEPTH, idx);
         end
      fork
         drive_words(3, idx, 1'b0, "test_buffer_stall");
         collect_outputs(1'b0, "test_buffer_stall");
      join
      check_quiet("test_buffer_stall");
   endtask

   // second frame follows the end-of-frame restart without a reset
   task automatic test_two_frames();
      apply_reset();
      run_frame(4, 1'b0, 1'b0, "test_two_frames");
      run_frame(5, 1'b1, 1'b1, "test_two_frames");
   endtask

   initial begin
      clk            = 1'b0;
      resetn         = 1'b0;
      s_data_i       = '0;
      s_valid_i      = 1'b0;
      m_ready_i      = 1'b0;
      mismatch_count = 0;
      other_count    = 0;
      seed           = $urandom(32'h33dc_9ef3);

      test_after_reset();
      test_single_frame();
      test_backpressure();
      test_input_gaps();
      test_buffer_stall();
      test_two_frames();

      $display("error counts: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatch_count, other_count, swu_top_i.swu_chk_i.fail_count);
      if (mismatch_count == 0 && other_count == 0 && swu_top_i.swu_chk_i.fail_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- swu_top.sv
`timescale 1ns/1ns

module swu_top
   import swu_geom_pkg::*, swu_stream_pkg::*;
(
   input  logic  clk,
   input  logic  resetn,
   input  word_t s_data_i,
   input  logic  s_valid_i,
   output logic  s_ready_o,
   output word_t m_data_o,
   output logic  m_valid_o,
   input  logic  m_ready_i
);

   elem_idx_t wr_count;
   elem_idx_t release_base;
   buf_addr_t rd_addr;
   word_t     rd_data;
   logic      rd_en;
   logic      rd_last;
   logic      pipe_free;
   logic      frame_done;

   swu_line_buffer line_buffer_i (
      .clk            (clk),
      .resetn         (resetn),
      .s_data_i       (s_data_i),
      .s_valid_i      (s_valid_i),
      .s_ready_o      (s_ready_o),
      .rd_en_i        (rd_en),
      .rd_addr_i      (rd_addr),
      .release_base_i (release_base),
      .frame_done_i   (frame_done),
      .rd_data_o      (rd_data),
      .wr_count_o     (wr_count)
   );

   swu_window_seq window_seq_i (
      .clk            (clk),
      .resetn         (resetn),
      .wr_count_i     (wr_count),
      .pipe_free_i    (pipe_free),
      .frame_done_i   (frame_done),
      .rd_en_o        (rd_en),
      .rd_addr_o      (rd_addr),
      .rd_last_o      (rd_last),
      .release_base_o (release_base)
   );

   swu_out_pipe out_pipe_i (
      .clk          (clk),
      .resetn       (resetn),
      .rd_en_i      (rd_en),
      .rd_last_i    (rd_last),
      .rd_data_i    (rd_data),
      .m_data_o     (m_data_o),
      .m_valid_o    (m_valid_o),
      .m_ready_i    (m_ready_i),
      .pipe_free_o  (pipe_free),
      .frame_done_o (frame_done)
   );

endmodule

//--- swu_window_seq.sv
`timescale 1ns/1ns
`include "swu_macros.svh"

module swu_window_seq
   import swu_geom_pkg::*;
(
   input  logic      clk,
   input  logic      resetn,
   input  elem_idx_t wr_count_i,
   input  logic      pipe_free_i,
   input  logic      frame_done_i,
   output logic      rd_en_o,
   output buf_addr_t rd_addr_o,
   output logic      rd_last_o,
   output elem_idx_t release_base_o
);

   localparam int CH        = `SWU_CH_WORDS;
   localparam int S         = `SWU_STRIDE;
   localparam int K         = `SWU_K;
   localparam int ROW_WORDS = `SWU_IFM_W * CH;
   localparam int DEPTH     = `SWU_BUF_DEPTH;
   localparam int REL_STEP  = S * ROW_WORDS;

   // address steps between consecutive reads, taken modulo the depth
   localparam int D_KROW = (ROW_WORDS - K * CH + 1) % DEPTH;
   localparam int D_OCOL = (2 * DEPTH + S * CH + 1
                            - (K - 1) * ROW_WORDS - K * CH) % DEPTH;
   localparam int D_OROW = (2 * DEPTH + S * ROW_WORDS + 1 - (K - 1) * ROW_WORDS
                            - ((`SWU_OFM_W - 1) * S + K) * CH) % DEPTH;

   chw_t      chw_q;
   kpos_t     kc_q;
   kpos_t     kr_q;
   ofm_col_t  oc_q;
   ofm_row_t  or_q;
   buf_addr_t addr_q;
   elem_idx_t rel_q;
   logic      done_q;

   elem_idx_t need_idx;
   buf_addr_t addr_inc;
   logic      row_end;
   logic      win_end;
   logic      orow_end;
   logic      frame_end;

   function automatic buf_addr_t wrap_add(input buf_addr_t addr, input buf_addr_t inc);
      logic [ADDR_W:0] sum;
      sum = {1'b0, addr} + {1'b0, inc};
      if (sum >= (ADDR_W+1)'(DEPTH)) begin
         sum = sum - (ADDR_W+1)'(DEPTH);
      end
      return buf_addr_t'(sum);
   endfunction

   ////////////////////
   // window position
   ////////////////////

   assign row_end   = (chw_q == chw_t'(CH - 1)) && (kc_q == kpos_t'(K - 1));
   assign win_end   = row_end && (kr_q == kpos_t'(K - 1));
   assign orow_end  = win_end && (oc_q == ofm_col_t'(`SWU_OFM_W - 1));
   assign frame_end = orow_end && (or_q == ofm_row_t'(`SWU_OFM_H - 1));

   // input word the current window element comes from
   assign need_idx = elem_idx_t'(((int'(or_q) * S + int'(kr_q)) * `SWU_IFM_W
                                  + int'(oc_q) * S + int'(kc_q)) * CH + int'(chw_q));

   // only read words already in the buffer
   assign rd_en_o = !done_q && pipe_free_i && (need_idx < wr_count_i);

   always_comb begin
      if (!row_end) begin
         addr_inc = buf_addr_t'(1);
      end else if (!win_end) begin
         addr_inc = buf_addr_t'(D_KROW);
      end else if (!orow_end) begin
         addr_inc = buf_addr_t'(D_OCOL);
      end else begin
         addr_inc = buf_addr_t'(D_OROW);
      end
   end

   ////////////////////
   // counters
   ////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         chw_q <= '0;
         kc_q  <= '0;
         kr_q  <= '0;
         oc_q  <= '0;
         or_q  <= '0;
      end else if (rd_en_o) begin
         chw_q <= (chw_q == chw_t'(CH - 1)) ? '0 : chw_q + 1'b1;
         if (chw_q == chw_t'(CH - 1)) begin
            kc_q <= (kc_q == kpos_t'(K - 1)) ? '0 : kc_q + 1'b1;
         end
         if (row_end) begin
            kr_q <= (kr_q == kpos_t'(K - 1)) ? '0 : kr_q + 1'b1;
         end
         if (win_end) begin
            oc_q <= (oc_q == ofm_col_t'(`SWU_OFM_W - 1)) ? '0 : oc_q + 1'b1;
         end
         if (orow_end) begin
            or_q <= frame_end ? '0 : or_q + 1'b1;
         end
      end
   end

   // address, release base and end of frame
   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         addr_q <= '0;
         rel_q  <= '0;
         done_q <= 1'b0;
      end else if (rd_en_o) begin
         addr_q <= frame_end ? '0 : wrap_add(addr_q, addr_inc);
         // next output row starts stride rows further down
         if (orow_end && !frame_end) begin
            rel_q <= rel_q + elem_idx_t'(REL_STEP);
         end
         if (frame_end) begin
            done_q <= 1'b1;
         end
      end
   end

   assign rd_addr_o      = addr_q;
   assign rd_last_o      = frame_end;
   assign release_base_o = rel_q;

endmodule

//--- verilog.f
+incdir+.
swu_geom_pkg.sv
swu_stream_pkg.sv
swu_line_buffer.sv
swu_window_seq.sv
swu_out_pipe.sv
swu_top.sv
swu_chk.sv
swu_tb.sv
